//--- verilog/div_consts.svh
/*
 * Division path constants
 * Operand width, destination register width and the divider iteration count
 */
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// Operand and result width of the integer datapath
`define DIV_XLEN 32

// Destination register address width, for 32 architectural registers
`define DIV_RADDR_W 5

// The core retires one quotient bit per cycle, so it needs one cycle per operand bit
`define DIV_ITER_CYCLES `DIV_XLEN

`endif

//--- verilog/div_pkg.sv
/*
 * Division path types
 * Opcode and controller state encodings and the records that move
 * between the execute stage, the divider unit and writeback
 */
`include "div_consts.svh"

package div_pkg;

	// Encoding follows the execute stage decoder of the core
	typedef enum logic [1:0] {
		DIV  = 2'd0,
		DIVU = 2'd1,
		REM  = 2'd2,
		REMU = 2'd3
	} div_op_e;

	// Four-state controller of the divider unit
	typedef enum logic [1:0] {
		ST_RESET    = 2'd0,
		ST_WAIT     = 2'd1,
		ST_DIVIDING = 2'd2,
		ST_DONE     = 2'd3
	} div_state_e;

	// One division instruction as it sits in the execute register
	typedef struct packed {
		div_op_e                 op;
		logic [`DIV_XLEN-1:0]    opA;
		logic [`DIV_XLEN-1:0]    opB;
		logic [`DIV_RADDR_W-1:0] rd;
	} div_instr_t;

	// Both results of one core, the quotient sits in the upper half
	typedef struct packed {
		logic [`DIV_XLEN-1:0] quotient;
		logic [`DIV_XLEN-1:0] remainder;
	} div_result_t;

	// Writeback record handed to the register file
	typedef struct packed {
		logic [`DIV_RADDR_W-1:0] rd;
		logic [`DIV_XLEN-1:0]    data;
	} div_wb_t;

endpackage

//--- verilog/radix2_divider.sv
/*
 * Radix-2 restoring divider
 * Produces one quotient bit per clock after a start pulse.
 * With SIGNED_OPS set the operands are two's complement and the results are
 * sign corrected to RISC-V rules, including division by zero
 */
`timescale 1ns/1ns
`include "div_consts.svh"

module radix2_divider #(
	parameter int SIGNED_OPS = 0
) (
	input  logic                  CLK,
	input  logic                  nrst,
	input  logic                  start,
	input  logic [`DIV_XLEN-1:0]  dividend,
	input  logic [`DIV_XLEN-1:0]  divisor,
	output div_pkg::div_result_t  result,
	output logic                  done
);
	// Wide enough to hold the full iteration count
	localparam int CNT_W = $clog2(`DIV_ITER_CYCLES) + 1;

	logic             busy;
	logic [CNT_W-1:0] count;

	// Quotient register starts out holding the dividend and fills from the bottom
	logic [`DIV_XLEN-1:0] quo;
	logic [`DIV_XLEN-1:0] rem;
	logic [`DIV_XLEN-1:0] dsor;
	logic                 neg_quo;
	logic                 neg_rem;
	logic                 dsor_zero;

	logic                 dividend_neg;
	logic                 divisor_neg;
	logic [`DIV_XLEN-1:0] dividend_abs;
	logic [`DIV_XLEN-1:0] divisor_abs;
	logic [`DIV_XLEN:0]   shifted;
	logic [`DIV_XLEN:0]   diff;
	logic                 load;

	// An unsigned core never sees a negative operand
	assign dividend_neg = (SIGNED_OPS != 0) && dividend[`DIV_XLEN-1];
	assign divisor_neg  = (SIGNED_OPS != 0) && divisor[`DIV_XLEN-1];
	assign dividend_abs = dividend_neg ? -dividend : dividend;
	assign divisor_abs  = divisor_neg ? -divisor : divisor;

	// A start that arrives while busy is ignored
	assign load = start && !busy;

	// Next dividend bit enters the partial remainder, then a trial subtraction
	assign shifted = {rem, quo[`DIV_XLEN-1]};
	assign diff    = shifted - {1'b0, dsor};

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (load) begin
				busy  <= 1'b1;
				count <= CNT_W'(`DIV_ITER_CYCLES);
			end else if (busy) begin
				count <= count - 1'b1;
				// Last iteration, results are final after this edge
				if (count == CNT_W'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (load) begin
			quo       <= dividend_abs;
			rem       <= '0;
			dsor      <= divisor_abs;
			neg_quo   <= dividend_neg ^ divisor_neg;
			neg_rem   <= dividend_neg;
			dsor_zero <= (divisor == '0);
		end else if (busy) begin
			// A clear top bit means the subtraction did not borrow
			if (!diff[`DIV_XLEN]) begin
				rem <= diff[`DIV_XLEN-1:0];
				quo <= {quo[`DIV_XLEN-2:0], 1'b1};
			end else begin
				rem <= shifted[`DIV_XLEN-1:0];
				quo <= {quo[`DIV_XLEN-2:0], 1'b0};
			end
		end
	end

	// A zero divisor leaves an all ones quotient, which must stay unnegated
	assign result.quotient  = (neg_quo && !dsor_zero) ? -quo : quo;
	// The remainder takes the sign of the dividend
	assign result.remainder = neg_rem ? -rem : rem;

endmodule

//--- verilog/divider_unit.sv
/*
 * Divider unit
 * Starts the signed or the unsigned core for the instruction in EX, stalls
 * the pipeline while it runs and registers the quotient or the remainder
 */
`timescale 1ns/1ns
`include "div_consts.svh"

module divider_unit (
	input  logic                 CLK,
	input  logic                 nrst,
	input  logic [`DIV_XLEN-1:0] opA,
	input  logic [`DIV_XLEN-1:0] opB,
	input  logic                 div_valid,
	input  div_pkg::div_op_e     div_op,
	output logic                 div_running,
	output logic [`DIV_XLEN-1:0] DIVout
);
	div_pkg::div_state_e  state;
	div_pkg::div_state_e  next_state;

	logic                 is_signed;
	logic                 is_rem;
	logic                 signed_start;
	logic                 unsigned_start;
	logic                 signed_done;
	logic                 unsigned_done;
	logic                 sel_done;
	div_pkg::div_result_t signed_result;
	div_pkg::div_result_t unsigned_result;
	div_pkg::div_result_t sel_result;

	assign is_signed = (div_op == div_pkg::DIV) || (div_op == div_pkg::REM);
	assign is_rem    = (div_op == div_pkg::REM) || (div_op == div_pkg::REMU);

	// Start pulse lasts only the WAIT cycle, the state has moved on by the next one
	assign signed_start   = (state == div_pkg::ST_WAIT) && div_valid && is_signed;
	assign unsigned_start = (state == div_pkg::ST_WAIT) && div_valid && !is_signed;

	radix2_divider #(.SIGNED_OPS(1)) signed_core (
		.CLK      (CLK),
		.nrst     (nrst),
		.start    (signed_start),
		.dividend (opA),
		.divisor  (opB),
		.result   (signed_result),
		.done     (signed_done)
	);

	radix2_divider #(.SIGNED_OPS(0)) unsigned_core (
		.CLK      (CLK),
		.nrst     (nrst),
		.start    (unsigned_start),
		.dividend (opA),
		.divisor  (opB),
		.result   (unsigned_result),
		.done     (unsigned_done)
	);

	// The opcode is held in EX for the whole division, so it still picks the right core
	assign sel_done   = is_signed ? signed_done : unsigned_done;
	assign sel_result = is_signed ? signed_result : unsigned_result;

	always_ff @(posedge CLK) begin
		if (!nrst)
			state <= div_pkg::ST_RESET;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			div_pkg::ST_RESET:    next_state = div_pkg::ST_WAIT;
			div_pkg::ST_WAIT:     next_state = div_valid ? div_pkg::ST_DIVIDING : div_pkg::ST_WAIT;
			div_pkg::ST_DIVIDING: next_state = sel_done ? div_pkg::ST_DONE : div_pkg::ST_DIVIDING;
			default:              next_state = div_pkg::ST_WAIT;
		endcase
	end

	// Running rises in WAIT already, so the upstream stage holds from the next edge on
	always_comb begin
		case (state)
			div_pkg::ST_WAIT:     div_running = div_valid;
			div_pkg::ST_DIVIDING: div_running = 1'b1;
			default:              div_running = 1'b0;
		endcase
	end

	// Result is captured as the state moves to DONE, ready when EX retires
	always_ff @(posedge CLK) begin
		if (state == div_pkg::ST_DIVIDING && sel_done)
			DIVout <= is_rem ? sel_result.remainder : sel_result.quotient;
	end

endmodule

//--- verilog/ex_stage.sv
/*
 * Execute pipeline register for the division path
 * Holds the instruction while the divider stalls the pipeline and
 * registers the writeback record as the instruction leaves EX
 */
`timescale 1ns/1ns
`include "div_consts.svh"

module ex_stage (
	input  logic                 CLK,
	input  logic                 nrst,
	input  div_pkg::div_instr_t  instr,
	input  logic                 instr_valid,
	input  logic                 stall,
	output logic                 ex_valid,
	output div_pkg::div_op_e     ex_op,
	output logic [`DIV_XLEN-1:0] ex_opA,
	output logic [`DIV_XLEN-1:0] ex_opB,
	input  logic [`DIV_XLEN-1:0] result_data,
	output div_pkg::div_wb_t     wb,
	output logic                 wb_valid
);
	div_pkg::div_instr_t ex_instr;
	logic                retire;

	// A valid instruction with stall low can only be in the divider's DONE cycle
	assign retire = ex_valid && !stall;

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			ex_valid <= 1'b0;
			ex_instr <= '0;
		end else if (!stall) begin
			// The next instruction enters on the same edge the old one retires
			ex_valid <= instr_valid;
			ex_instr <= instr;
		end
	end

	assign ex_op  = ex_instr.op;
	assign ex_opA = ex_instr.opA;
	assign ex_opB = ex_instr.opB;

	// One pulse per retired instruction
	always_ff @(posedge CLK) begin
		if (!nrst)
			wb_valid <= 1'b0;
		else
			wb_valid <= retire;
	end

	// Divider result was registered one cycle earlier and is stable here
	always_ff @(posedge CLK) begin
		if (retire) begin
			wb.rd   <= ex_instr.rd;
			wb.data <= result_data;
		end
	end

endmodule

//--- verilog/div_subsystem.sv
/*
 * Division subsystem top level
 * Execute register and divider unit; the divider running flag is the stall
 */
`timescale 1ns/1ns
`include "div_consts.svh"

module div_subsystem (
	input  logic                CLK,
	input  logic                nrst,
	input  div_pkg::div_instr_t instr,
	input  logic                instr_valid,
	output logic                stall,
	output div_pkg::div_wb_t    wb,
	output logic                wb_valid
);
	logic                 ex_valid;
	div_pkg::div_op_e     ex_op;
	logic [`DIV_XLEN-1:0] ex_opA;
	logic [`DIV_XLEN-1:0] ex_opB;
	logic [`DIV_XLEN-1:0] result_data;

	ex_stage i_ex_stage (
		.CLK         (CLK),
		.nrst        (nrst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.ex_valid    (ex_valid),
		.ex_op       (ex_op),
		.ex_opA      (ex_opA),
		.ex_opB      (ex_opB),
		.result_data (result_data),
		.wb          (wb),
		.wb_valid    (wb_valid)
	);

	// Stall goes both to the upstream stage and back into the EX register
	divider_unit i_divider_unit (
		.CLK         (CLK),
		.nrst        (nrst),
		.opA         (ex_opA),
		.opB         (ex_opB),
		.div_valid   (ex_valid),
		.div_op      (ex_op),
		.div_running (stall),
		.DIVout      (result_data)
	);

endmodule

//--- verification/div_tb.sv
/*
 * Division subsystem testbench
 * Directed tests for DIV, DIVU, REM and REMU through the execute register,
 * checked against a RISC-V M-extension model, plus a stall and latency check
 */
`timescale 1ns/1ns
`include "div_consts.svh"

module div_tb;
	localparam int CLK_PERIOD = 8;
	localparam int STREAM_LEN = 40;
	// Unsigned 10, signed 8, corner cases 6, stream 40, stall test 3
	localparam int NUM_OPS    = 67;
	localparam int TIMEOUT_NS = NUM_OPS * (`DIV_ITER_CYCLES + 8) * CLK_PERIOD;

	logic                CLK;
	logic                nrst;
	div_pkg::div_instr_t instr;
	logic                instr_valid;
	logic                stall;
	div_pkg::div_wb_t    wb;
	logic                wb_valid;

	div_pkg::div_wb_t    expected_q[$];
	div_pkg::div_wb_t    observed_q[$];
	int                  issued_count;
	int                  writeback_count;
	logic [31:0]         lcg_state;

	div_subsystem i_div_subsystem (
		.CLK         (CLK),
		.nrst        (nrst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.wb          (wb),
		.wb_valid    (wb_valid)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// Ends a hung run once every operation has had its latency and a few spare cycles
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the divider did not finish all operations in %0d ns", TIMEOUT_NS);
		$display("TESTS FAILED");
		$fatal(1, "run aborted after timeout");
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// RISC-V M-extension result where signed division truncates toward zero
	function automatic logic [`DIV_XLEN-1:0] model_result(input div_pkg::div_op_e op,
			input logic [`DIV_XLEN-1:0] a, input logic [`DIV_XLEN-1:0] b);
		logic [`DIV_XLEN-1:0] most_neg;
		logic                 overflow;
		logic [`DIV_XLEN-1:0] res;
		most_neg = {1'b1, {(`DIV_XLEN-1){1'b0}}};
		overflow = (a == most_neg) && (b == '1);
		case (op)
			div_pkg::DIVU: res = (b == '0) ? '1 : a / b;
			div_pkg::REMU: res = (b == '0) ? a : a % b;
			div_pkg::DIV: begin
				if (b == '0)
					res = '1;
				else if (overflow)
					res = most_neg;
				else
					res = $signed(a) / $signed(b);
			end
			default: begin
				if (b == '0)
					res = a;
				else if (overflow)
					res = '0;
				else
					res = $signed(a) % $signed(b);
			end
		endcase
		return res;
	endfunction

	task automatic check_eq(input logic [31:0] expected, input logic [31:0] actual,
			input string what);
		if (expected !== actual) begin
			$display("mismatch at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	// Called on a falling edge and returns on the falling edge after the EX register took it
	task automatic issue(input div_pkg::div_op_e op, input logic [31:0] a,
			input logic [31:0] b, input logic [4:0] rd);
		div_pkg::div_wb_t expect_rec;
		instr.op    = op;
		instr.opA   = a;
		instr.opB   = b;
		instr.rd    = rd;
		instr_valid = 1'b1;
		expect_rec.rd   = rd;
		expect_rec.data = model_result(op, a, b);
		expected_q.push_back(expect_rec);
		// Stall only changes after a rising edge, so it is stable here
		while (stall)
			@(negedge CLK);
		@(negedge CLK);
		instr_valid = 1'b0;
		issued_count++;
	endtask

	task automatic collect_writebacks();
		forever begin
			@(negedge CLK);
			if (wb_valid) begin
				observed_q.push_back(wb);
				writeback_count++;
			end
		end
	endtask

	task automatic drain_and_compare(input string name);
		div_pkg::div_wb_t expect_rec;
		div_pkg::div_wb_t got_rec;
		while (observed_q.size() < expected_q.size())
			@(negedge CLK);
		// A few quiet cycles let a stray extra writeback show up in the count
		repeat (4) @(negedge CLK);
		check_eq(32'(expected_q.size()), 32'(observed_q.size()), {name, ": writeback count"});
		while (expected_q.size() > 0) begin
			expect_rec = expected_q.pop_front();
			got_rec    = observed_q.pop_front();
			check_eq(32'(expect_rec.rd), 32'(got_rec.rd), {name, ": rd"});
			check_eq(expect_rec.data, got_rec.data, {name, ": data"});
		end
	endtask

	task automatic idle_after_reset();
		repeat (8) begin
			@(negedge CLK);
			check_eq(32'd0, 32'(stall), "stall while idle");
			check_eq(32'd0, 32'(wb_valid), "wb_valid while idle");
		end
	endtask

	task automatic unsigned_division();
		logic [31:0] a_vals [5] = '{32'd100, 32'd7, 32'hdeadbeef, 32'hffffffff, 32'd12345678};
		logic [31:0] b_vals [5] = '{32'd7, 32'd100, 32'd1, 32'h10, 32'd12345678};
		for (int i = 0; i < 5; i++) begin
			issue(div_pkg::DIVU, a_vals[i], b_vals[i], 5'(i + 1));
			issue(div_pkg::REMU, a_vals[i], b_vals[i], 5'(i + 16));
		end
		drain_and_compare("unsigned");
	endtask

	// All four sign combinations of 17 and 5
	task automatic signed_division();
		logic [31:0] a_vals [4] = '{32'd17, -32'd17, 32'd17, -32'd17};
		logic [31:0] b_vals [4] = '{32'd5, 32'd5, -32'd5, -32'd5};
		for (int i = 0; i < 4; i++) begin
			issue(div_pkg::DIV, a_vals[i], b_vals[i], 5'(i + 3));
			issue(div_pkg::REM, a_vals[i], b_vals[i], 5'(i + 20));
		end
		drain_and_compare("signed");
	endtask

	task automatic division_corner_cases();
		issue(div_pkg::DIV, -32'd12345, 32'd0, 5'd1);
		issue(div_pkg::DIVU, 32'h12345678, 32'd0, 5'd2);
		issue(div_pkg::REM, -32'd12345, 32'd0, 5'd3);
		issue(div_pkg::REMU, 32'h12345678, 32'd0, 5'd4);
		// Most negative value over minus one
		issue(div_pkg::DIV, 32'h80000000, 32'hffffffff, 5'd5);
		issue(div_pkg::REM, 32'h80000000, 32'hffffffff, 5'd6);
		drain_and_compare("corner cases");
	endtask

	task automatic random_stream();
		logic [31:0]      r;
		logic [31:0]      a;
		logic [31:0]      b;
		div_pkg::div_op_e op;
		for (int i = 0; i < STREAM_LEN; i++) begin
			r = next_random();
			a = next_random();
			// Upper LCG bits pick a shift so small divisors also occur
			b = next_random() >> r[31:27];
			if (r[26:24] == 3'd0)
				b = '0;
			op = div_pkg::div_op_e'(r[23:22]);
			issue(op, a, b, r[21:17]);
		end
		drain_and_compare("random stream");
	endtask

	task automatic stall_and_latency();
		int k;
		issue(div_pkg::DIV, 32'd1000, -32'd7, 5'd9);
		k = 0;
		// Stall holds through WAIT and DIVIDING and drops for the DONE cycle
		while (!wb_valid) begin
			check_eq(32'(k < `DIV_ITER_CYCLES + 2), 32'(stall), "stall while dividing");
			@(negedge CLK);
			k++;
		end
		check_eq(32'(`DIV_ITER_CYCLES + 3), 32'(k), "issue to writeback latency");
		// The DIVU is presented while the REMU stalls the pipeline and waits out its division
		issue(div_pkg::REMU, 32'd99, 32'd10, 5'd10);
		issue(div_pkg::DIVU, 32'd99, 32'd10, 5'd11);
		drain_and_compare("stall hold");
	endtask

	initial collect_writebacks();

	initial begin
		instr           = '0;
		instr_valid     = 1'b0;
		nrst            = 1'b0;
		issued_count    = 0;
		writeback_count = 0;
		lcg_state       = 32'd53;
		repeat (4) @(negedge CLK);
		nrst = 1'b1;
		idle_after_reset();
		unsigned_division();
		signed_division();
		division_corner_cases();
		random_stream();
		stall_and_latency();
		// Long enough for a duplicated instruction to complete a whole division
		repeat (`DIV_ITER_CYCLES + 4) @(negedge CLK);
		check_eq(32'(issued_count), 32'(writeback_count), "issued against retired instructions");
		check_eq(32'd0, 32'(stall), "stall after the last writeback");
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- list.f
+incdir+verilog
verilog/div_pkg.sv
verilog/radix2_divider.sv
verilog/divider_unit.sv
verilog/ex_stage.sv
verilog/div_subsystem.sv
verification/div_tb.sv

//--- run.sh
#!/bin/sh
# Builds the division subsystem testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module div_tb -f list.f -o div_sim > sim.log 2>&1 &&
	./obj_dir/div_sim >> sim.log 2>&1
grep -q "^TESTS PASSED$" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }
